// ==== src/etx_pkg.sv ====
package etx_pkg;

   localparam int AW         = 32;                  // Address field width
   localparam int DW         = 32;                  // Data field width
   localparam int CMD_W      = 8;                   // Command field width

   // Packet layout, source address in the low bits
   localparam int SRC_LSB    = 0;
   localparam int DATA_LSB   = SRC_LSB + AW;        // Data above source
   localparam int DST_LSB    = DATA_LSB + DW;       // Destination above data
   localparam int CMD_LSB    = DST_LSB + AW;        // Command on top
   localparam int PW         = CMD_LSB + CMD_W;     // 104 bit packet

   localparam int NCH        = 3;                   // wr, rd, rr streams
   localparam int CHW        = $clog2(NCH);         // Channel index width
   localparam int FIFO_DEPTH = 4;                   // Entries per channel
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // Buffer pointer width

   // Channel index doubles as priority, higher wins
   localparam int CH_WR      = 0;
   localparam int CH_RD      = 1;
   localparam int CH_RR      = 2;

   typedef enum logic [CMD_W-1:0] {
      OP_WRITE = 8'h01,                             // Write request
      OP_READ  = 8'h02,                             // Read request
      OP_RESP  = 8'h03                              // Read response
   } etx_opcode_e;

   typedef enum logic [1:0] {
      REG_CTRL      = 2'd0,                         // [0] tx_enable, [1] remap_enable
      REG_REMAP_SEL = 2'd1,                         // Destination bit mask
      REG_REMAP_PAT = 2'd2                          // Replacement pattern
   } etx_reg_e;

endpackage

// ==== src/etx_fifo.sv ====
module etx_fifo (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   in_access,
   input  logic [etx_pkg::PW-1:0] in_packet,
   output logic                   in_wait,
   input  logic                   pop,
   output logic                   head_valid,
   output logic [etx_pkg::PW-1:0] head_packet
);
   import etx_pkg::*;

   logic [PW-1:0]      mem [FIFO_DEPTH];             // Packet storage
   logic [FIFO_AW-1:0] wr_ptr;                       // Next free slot
   logic [FIFO_AW-1:0] rd_ptr;                       // Oldest entry
   logic [FIFO_AW:0]   count;                        // Occupancy
   logic [FIFO_AW:0]   count_next;
   logic               push;
   logic               pull;

   assign push        = in_access & ~in_wait;        // Sender handshake
   assign pull        = pop & head_valid;            // Never pop when empty
   assign head_valid  = (count != '0);
   assign head_packet = mem[rd_ptr];                 // Head shown straight from storage

   always_comb begin
      count_next = count;
      if (push && !pull) begin
         count_next = count + 1'b1;
      end else if (pull && !push) begin
         count_next = count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_packet;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         in_wait <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;                 // Power of two depth, wraps
         end
         if (pull) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count   <= count_next;
         in_wait <= (count_next == FIFO_DEPTH);      // Registered full flag
      end
   end

endmodule

// ==== src/etx_arbiter.sv ====
module etx_arbiter (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic [etx_pkg::NCH-1:0] head_valid,
   input  logic [etx_pkg::PW-1:0]  head_packet [etx_pkg::NCH],
   output logic [etx_pkg::NCH-1:0] pop,
   input  logic                    stall,
   output logic                    arb_access,
   output logic [etx_pkg::PW-1:0]  arb_packet,
   output logic                    arb_resp
);
   import etx_pkg::*;

   logic [CHW-1:0] sel;                              // Winning channel
   logic           any;                              // Some buffer nonempty
   logic           load;                             // Output register takes new data

   assign any  = |head_valid;
   assign load = ~arb_access | ~stall;               // Empty or moving on

   // Ascending scan, last hit is the highest priority
   always_comb begin
      sel = CHW'(CH_WR);
      for (int i = 0; i < NCH; i++) begin
         if (head_valid[i]) begin
            sel = CHW'(i);
         end
      end
   end

   always_comb begin
      pop = '0;
      if (load && any) begin
         pop[sel] = 1'b1;                            // One pop per granted cycle
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         arb_access <= 1'b0;
         arb_resp   <= 1'b0;
      end else if (load) begin
         arb_access <= any;
         arb_resp   <= any & (sel == CHW'(CH_RR));  // Response path skips remap
      end
   end

   always_ff @(posedge clk) begin
      if (load && any) begin
         arb_packet <= head_packet[sel];
      end
   end

   // Unused grants wait in their buffers while stalled
   // Order inside a channel is kept by the FIFO itself

endmodule

// ==== src/etx_cfg.sv ====
module etx_cfg (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cfg_write,
   input  etx_pkg::etx_reg_e      cfg_addr,
   input  logic [etx_pkg::DW-1:0] cfg_data,
   output logic                   tx_enable,
   output logic                   remap_enable,
   output logic [etx_pkg::AW-1:0] remap_sel,
   output logic [etx_pkg::AW-1:0] remap_pat
);
   import etx_pkg::*;

   // All registers clear, link idle until software enables it
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_enable    <= 1'b0;
         remap_enable <= 1'b0;
         remap_sel    <= '0;
         remap_pat    <= '0;
      end else if (cfg_write) begin
         case (cfg_addr)
            REG_CTRL: begin
               tx_enable    <= cfg_data[0];          // Gates output loads
               remap_enable <= cfg_data[1];          // Destination rewrite on
            end
            REG_REMAP_SEL: begin
               remap_sel <= cfg_data;                // Bits to replace
            end
            REG_REMAP_PAT: begin
               remap_pat <= cfg_data;                // Replacement values
            end
            default: begin
               // Unmapped address, write dropped
            end
         endcase
      end
   end

   // Write only block, no readback path
   // One register updated per write cycle

endmodule

// ==== src/etx_remap.sv ====
module etx_remap (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   arb_access,
   input  logic [etx_pkg::PW-1:0] arb_packet,
   input  logic                   arb_resp,
   input  logic                   remap_enable,
   input  logic [etx_pkg::AW-1:0] remap_sel,
   input  logic [etx_pkg::AW-1:0] remap_pat,
   input  logic                   stall,
   output logic                   remap_access,
   output logic [etx_pkg::PW-1:0] remap_packet
);
   import etx_pkg::*;

   logic [AW-1:0] dst_in;                            // Incoming destination
   logic [AW-1:0] dst_out;                           // After rewrite
   logic          do_remap;
   logic [PW-1:0] new_packet;

   assign dst_in   = arb_packet[DST_LSB +: AW];
   assign do_remap = remap_enable & ~arb_resp;       // Responses bypass
   assign dst_out  = do_remap ? ((dst_in & ~remap_sel) | (remap_pat & remap_sel)) : dst_in;

   always_comb begin
      new_packet                  = arb_packet;      // Cmd, data, src untouched
      new_packet[DST_LSB +: AW]   = dst_out;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         remap_access <= 1'b0;
      end else if (!stall) begin
         remap_access <= arb_access;                 // Advance with the chain
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && arb_access) begin
         remap_packet <= new_packet;
      end
   end

endmodule

// ==== src/etx_protocol.sv ====
module etx_protocol (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   remap_access,
   input  logic [etx_pkg::PW-1:0] remap_packet,
   input  logic                   tx_enable,
   input  logic                   tx_rd_wait,
   input  logic                   tx_wr_wait,
   output logic                   stall,
   output logic                   tx_access,
   output logic [etx_pkg::PW-1:0] tx_packet,
   output logic                   tx_burst
);
   import etx_pkg::*;

   etx_opcode_e   cur_op;                            // Opcode on the link
   etx_opcode_e   nxt_op;                            // Opcode arriving
   logic [AW-1:0] cur_dst;
   logic [AW-1:0] nxt_dst;
   logic          link_wait;                         // Wait matching current opcode
   logic          xfer;                              // Transfer this cycle
   logic          hold;
   logic          is_burst;

   assign cur_op  = etx_opcode_e'(tx_packet[CMD_LSB +: CMD_W]);
   assign nxt_op  = etx_opcode_e'(remap_packet[CMD_LSB +: CMD_W]);
   assign cur_dst = tx_packet[DST_LSB +: AW];
   assign nxt_dst = remap_packet[DST_LSB +: AW];

   always_comb begin
      case (cur_op)
         OP_READ:           link_wait = tx_rd_wait;
         OP_WRITE, OP_RESP: link_wait = tx_wr_wait;
         default:           link_wait = tx_wr_wait;
      endcase
   end

   assign xfer  = tx_access & ~link_wait;
   assign hold  = tx_access & link_wait;
   assign stall = ~tx_enable | hold;                 // Disabled core accepts nothing

   // Write following a write that leaves this cycle, 4 bytes further on
   assign is_burst = xfer & (cur_op == OP_WRITE) & (nxt_op == OP_WRITE)
                     & (nxt_dst == cur_dst + AW'(4));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_access <= 1'b0;
         tx_burst  <= 1'b0;
      end else if (!stall) begin
         tx_access <= remap_access;
         tx_burst  <= remap_access & is_burst;
      end else if (xfer) begin
         tx_access <= 1'b0;                          // Last packet drains while disabled
         tx_burst  <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && remap_access) begin
         tx_packet <= remap_packet;                  // Held through link wait
      end
   end

endmodule

// ==== src/etx_core.sv ====
module etx_core (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   txwr_access,
   input  logic [etx_pkg::PW-1:0] txwr_packet,
   output logic                   txwr_wait,
   input  logic                   txrd_access,
   input  logic [etx_pkg::PW-1:0] txrd_packet,
   output logic                   txrd_wait,
   input  logic                   txrr_access,
   input  logic [etx_pkg::PW-1:0] txrr_packet,
   output logic                   txrr_wait,
   input  logic                   cfg_write,
   input  etx_pkg::etx_reg_e      cfg_addr,
   input  logic [etx_pkg::DW-1:0] cfg_data,
   output logic                   tx_access,
   output logic [etx_pkg::PW-1:0] tx_packet,
   output logic                   tx_burst,
   input  logic                   tx_rd_wait,
   input  logic                   tx_wr_wait
);
   import etx_pkg::*;

   logic [NCH-1:0] ch_access;                        // Streams gathered by channel index
   logic [NCH-1:0] ch_wait;
   logic [PW-1:0]  ch_packet   [NCH];
   logic [NCH-1:0] head_valid;
   logic [PW-1:0]  head_packet [NCH];
   logic [NCH-1:0] pop;
   logic           stall;                            // From output stage, whole chain
   logic           arb_access;
   logic [PW-1:0]  arb_packet;
   logic           arb_resp;
   logic           remap_access;
   logic [PW-1:0]  remap_packet;
   logic           tx_enable;
   logic           remap_enable;
   logic [AW-1:0]  remap_sel;
   logic [AW-1:0]  remap_pat;

   assign ch_access[CH_WR] = txwr_access;
   assign ch_access[CH_RD] = txrd_access;
   assign ch_access[CH_RR] = txrr_access;
   assign ch_packet[CH_WR] = txwr_packet;
   assign ch_packet[CH_RD] = txrd_packet;
   assign ch_packet[CH_RR] = txrr_packet;
   assign txwr_wait        = ch_wait[CH_WR];
   assign txrd_wait        = ch_wait[CH_RD];
   assign txrr_wait        = ch_wait[CH_RR];

   for (genvar g = 0; g < NCH; g++) begin : g_ch
      etx_fifo u_fifo (
         .clk         (clk),
         .arst_n      (arst_n),
         .in_access   (ch_access[g]),
         .in_packet   (ch_packet[g]),
         .in_wait     (ch_wait[g]),
         .pop         (pop[g]),
         .head_valid  (head_valid[g]),
         .head_packet (head_packet[g])
      );
   end

   etx_arbiter u_arbiter (
      .clk         (clk),
      .arst_n      (arst_n),
      .head_valid  (head_valid),
      .head_packet (head_packet),
      .pop         (pop),
      .stall       (stall),
      .arb_access  (arb_access),
      .arb_packet  (arb_packet),
      .arb_resp    (arb_resp)
   );

   etx_cfg u_cfg (
      .clk          (clk),
      .arst_n       (arst_n),
      .cfg_write    (cfg_write),
      .cfg_addr     (cfg_addr),
      .cfg_data     (cfg_data),
      .tx_enable    (tx_enable),
      .remap_enable (remap_enable),
      .remap_sel    (remap_sel),
      .remap_pat    (remap_pat)
   );

   etx_remap u_remap (
      .clk          (clk),
      .arst_n       (arst_n),
      .arb_access   (arb_access),
      .arb_packet   (arb_packet),
      .arb_resp     (arb_resp),
      .remap_enable (remap_enable),
      .remap_sel    (remap_sel),
      .remap_pat    (remap_pat),
      .stall        (stall),
      .remap_access (remap_access),
      .remap_packet (remap_packet)
   );

   etx_protocol u_protocol (
      .clk          (clk),
      .arst_n       (arst_n),
      .remap_access (remap_access),
      .remap_packet (remap_packet),
      .tx_enable    (tx_enable),
      .tx_rd_wait   (tx_rd_wait),
      .tx_wr_wait   (tx_wr_wait),
      .stall        (stall),
      .tx_access    (tx_access),
      .tx_packet    (tx_packet),
      .tx_burst     (tx_burst)
   );

endmodule

// ==== testbench/etx_core_assert.sv ====
module etx_core_assert (
   input logic                    clk,
   input logic                    arst_n,
   input logic                    tx_access,
   input logic [etx_pkg::PW-1:0]  tx_packet,
   input logic                    tx_rd_wait,
   input logic                    tx_wr_wait,
   input logic [etx_pkg::NCH-1:0] ch_wait,
   input logic [etx_pkg::NCH-1:0] pop
);
   timeunit 1ns;
   timeprecision 100ps;
   import etx_pkg::*;

   logic held;                                       // Output stalled by its link wait

   assign held = tx_access & ((tx_packet[CMD_LSB +: 8] == OP_READ) ? tx_rd_wait : tx_wr_wait);

   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      held |=> tx_access && $stable(tx_packet))
      else $error("tx_packet changed while the link was waiting");

   a_reset: assert property (@(posedge clk) $rose(arst_n) |-> !tx_access)
      else $error("tx_access high in the first cycle after reset");

   // Full buffer takes no push, so it stays full until a pop
   for (genvar g = 0; g < NCH; g++) begin : g_full
      a_full: assert property (@(posedge clk) disable iff (!arst_n)
         ch_wait[g] |=> ch_wait[g] || $past(pop[g]))
         else $error("channel %0d accepted a push while its wait was high", g);
   end

endmodule

bind etx_core etx_core_assert u_assert (
   .clk        (clk),
   .arst_n     (arst_n),
   .tx_access  (tx_access),
   .tx_packet  (tx_packet),
   .tx_rd_wait (tx_rd_wait),
   .tx_wr_wait (tx_wr_wait),
   .ch_wait    (ch_wait),
   .pop        (pop)
);

// ==== testbench/etx_core_tb.sv ====
module etx_core_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import etx_pkg::*;

   localparam int MAX_CYCLES = 4000;                 // About 250 packets at worst stall rate

   logic           clk = 1'b0;
   logic           arst_n = 1'b0;
   logic [NCH-1:0] acc = '0;                         // Stream access by channel index
   logic [PW-1:0]  pk [NCH];
   logic [NCH-1:0] waits;
   logic           cfg_write = 1'b0;
   etx_reg_e       cfg_addr = REG_CTRL;
   logic [DW-1:0]  cfg_data = '0;
   logic           tx_rd_wait = 1'b0;
   logic           tx_wr_wait = 1'b0;
   logic           tx_access;
   logic [PW-1:0]  tx_packet;
   logic           tx_burst;
   integer         seed = 32'h9c43a6cf;
   logic [PW-1:0]  exp_q [NCH][$];                   // Expected packets per channel
   logic           m_remap_en = 1'b0;                // Model copy of the registers
   logic [AW-1:0]  m_sel = '0;
   logic [AW-1:0]  m_pat = '0;
   logic           link_rand = 1'b0;                 // Random link back-pressure on
   int             errors = 0;
   int             test_errors = 0;
   int             ntests = 0;
   int             xfers = 0;
   int             dut_bursts = 0;                   // Bursts flagged by the DUT
   int             cycles = 0;
   int             snap;
   string          test_name = "reset";
   int             mcyc = 0;                         // Monitor state
   int             start_cyc = 0;
   int             prev_cyc = -10;
   etx_opcode_e    prev_op = OP_READ;
   logic [AW-1:0]  prev_dst = '0;
   logic           last_access = 1'b0;
   logic           last_xfer = 1'b0;

   // Destination steps where one gap of 8 breaks the burst
   int n_offs [8] = '{0, 4, 8, 12, 20, 24, 28, 32};

   etx_core DUT (
      .clk (clk), .arst_n (arst_n),
      .txwr_access (acc[CH_WR]), .txwr_packet (pk[CH_WR]), .txwr_wait (waits[CH_WR]),
      .txrd_access (acc[CH_RD]), .txrd_packet (pk[CH_RD]), .txrd_wait (waits[CH_RD]),
      .txrr_access (acc[CH_RR]), .txrr_packet (pk[CH_RR]), .txrr_wait (waits[CH_RR]),
      .cfg_write (cfg_write), .cfg_addr (cfg_addr), .cfg_data (cfg_data),
      .tx_access (tx_access), .tx_packet (tx_packet), .tx_burst (tx_burst),
      .tx_rd_wait (tx_rd_wait), .tx_wr_wait (tx_wr_wait)
   );

   always #2 clk = ~clk;                             // 4 ns period

   function automatic logic [PW-1:0] rand_pkt(input int ch);
      etx_opcode_e op;
      op = (ch == CH_RD) ? OP_READ : (ch == CH_RR) ? OP_RESP : OP_WRITE;
      return {op, $random(seed), $random(seed), $random(seed)};
   endfunction

   // Selected destination bits of requests come from the pattern
   function automatic logic [PW-1:0] remapped(input logic [PW-1:0] p);
      logic [PW-1:0] q;
      q = p;
      if (m_remap_en && p[CMD_LSB +: 8] != OP_RESP) begin
         for (int b = 0; b < AW; b++) begin
            if (m_sel[b]) q[DST_LSB + b] = m_pat[b];
         end
      end
      return q;
   endfunction

   task automatic report(input string what, input logic [PW-1:0] want, input logic [PW-1:0] got);
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, want, got);
      errors++;
      test_errors++;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      ntests++;
      $display("test %0d %s %s, %0d errors", ntests, test_name,
               (test_errors == 0) ? "passed" : "failed", test_errors);
   endtask

   task automatic write_cfg(input etx_reg_e a, input logic [DW-1:0] d);
      cfg_write <= 1'b1;
      cfg_addr  <= a;
      cfg_data  <= d;
      @(posedge clk);
      cfg_write <= 1'b0;
      case (a)
         REG_CTRL:      m_remap_en = d[1];
         REG_REMAP_SEL: m_sel = d;
         REG_REMAP_PAT: m_pat = d;
         default: ;
      endcase
   endtask

   // Holds access until the buffer takes the packet and leaves it high
   task automatic send(input int ch, input logic [PW-1:0] p);
      acc[ch] <= 1'b1;
      pk[ch]  <= p;
      do @(posedge clk); while (waits[ch]);
   endtask

   task automatic stream(input int ch, input int n, input int max_gap);
      int gap;
      for (int i = 0; i < n; i++) begin
         send(ch, rand_pkt(ch));
         gap = {$random(seed)} % (max_gap + 1);
         if (gap > 0) begin
            acc[ch] <= 1'b0;
            repeat (gap) @(posedge clk);
         end
      end
      acc[ch] <= 1'b0;
   endtask

   task automatic wait_drain();
      do @(posedge clk); while (exp_q[CH_WR].size() + exp_q[CH_RD].size()
                                + exp_q[CH_RR].size() != 0);
   endtask

   always @(posedge clk) begin
      if (link_rand) begin
         tx_rd_wait <= ($random(seed) & 3) == 0;     // 25 percent wait
         tx_wr_wait <= ($random(seed) & 3) == 0;
      end else begin
         tx_rd_wait <= 1'b0;
         tx_wr_wait <= 1'b0;
      end
   end

   always @(posedge clk) begin : monitor
      etx_opcode_e   op;
      int            ch;
      logic          xfer;
      logic          want_burst;
      logic [PW-1:0] want;
      xfer = 1'b0;
      if (arst_n) begin
         for (int c = 0; c < NCH; c++) begin
            if (acc[c] && !waits[c]) begin
               exp_q[c].push_back(remapped(pk[c]));  // Accepted at this edge
            end
         end
         if (tx_access) begin
            if (!last_access || last_xfer) begin
               start_cyc = mcyc;                     // New packet on the link
            end
            op   = etx_opcode_e'(tx_packet[CMD_LSB +: 8]);
            xfer = !((op == OP_READ) ? tx_rd_wait : tx_wr_wait);
         end
         if (xfer) begin
            ch = (op == OP_READ) ? CH_RD : (op == OP_RESP) ? CH_RR : CH_WR;
            want_burst = (start_cyc == prev_cyc + 1) && (prev_op == OP_WRITE)
                         && (op == OP_WRITE)
                         && (tx_packet[DST_LSB +: AW] == prev_dst + 32'd4);
            if (exp_q[ch].size() == 0) begin
               $display("ERROR %s: packet %h arrived but was never sent", test_name, tx_packet);
               errors++;
               test_errors++;
            end else begin
               want = exp_q[ch].pop_front();         // Per-channel order
               if (tx_packet !== want) report("tx_packet", want, tx_packet);
            end
            if (tx_burst !== want_burst) report("tx_burst", want_burst, tx_burst);
            if (tx_burst) dut_bursts++;
            prev_cyc = mcyc;
            prev_op  = op;
            prev_dst = tx_packet[DST_LSB +: AW];
            xfers++;
         end
         last_access = tx_access;
         last_xfer   = xfer;
      end
      mcyc++;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin
      int n;
      logic [AW-1:0] base;
      foreach (pk[i]) pk[i] = '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      start_test("disabled_fill");
      if ({tx_access, tx_burst, waits} !== '0) begin
         report("idle outputs", '0, {tx_access, tx_burst, waits});
      end
      for (int c = 0; c < NCH; c++) begin
         acc[c] <= 1'b1;
         pk[c]  <= rand_pkt(c);
      end
      n = 0;
      while (waits != '1 && n < 40) begin
         @(posedge clk);
         for (int c = 0; c < NCH; c++) begin
            if (!waits[c]) pk[c] <= rand_pkt(c);     // Next packet once this one is taken
         end
         n++;
      end
      acc <= '0;
      if (waits !== '1) report("channel waits", {NCH{1'b1}}, waits);
      if (xfers != 0) report("link transfers", 0, xfers);
      end_test();

      start_test("single_write");
      write_cfg(REG_CTRL, 32'h1);
      stream(CH_WR, 20, 2);
      wait_drain();
      end_test();

      start_test("remap");
      write_cfg(REG_REMAP_SEL, $random(seed));
      write_cfg(REG_REMAP_PAT, $random(seed));
      write_cfg(REG_CTRL, 32'h3);
      fork
         stream(CH_WR, 10, 1);
         stream(CH_RD, 10, 1);
         stream(CH_RR, 10, 1);
      join
      wait_drain();
      write_cfg(REG_CTRL, 32'h1);
      end_test();

      start_test("random_traffic");
      link_rand = 1'b1;
      fork
         stream(CH_WR, 40, 3);
         stream(CH_RD, 40, 3);
         stream(CH_RR, 40, 3);
      join
      wait_drain();
      link_rand = 1'b0;
      end_test();

      start_test("burst");
      snap = dut_bursts;
      base = $random(seed) & 32'hffff_fffc;
      foreach (n_offs[i]) begin
         send(CH_WR, {OP_WRITE, base + n_offs[i], $random(seed), $random(seed)});
      end
      acc[CH_WR] <= 1'b0;
      wait_drain();
      n = 0;
      for (int i = 1; i < 8; i++) begin
         if (n_offs[i] == n_offs[i-1] + 4) n++;      // Step of 4 continues the burst
      end
      if (dut_bursts - snap != n) report("burst count", n, dut_bursts - snap);
      end_test();

      start_test("enable_toggle");
      snap = xfers;
      fork
         stream(CH_WR, 30, 0);
         begin
            wait (xfers >= snap + 6);
            write_cfg(REG_CTRL, 32'h0);
            while (tx_access) @(posedge clk);        // Last packet drains
            snap = xfers;
            repeat (20) @(posedge clk);
            if (xfers != snap) report("transfers while disabled", snap, xfers);
            write_cfg(REG_CTRL, 32'h1);
         end
      join
      wait_drain();
      end_test();

      $display("Summary: %0d tests, %0d packets, %0d failed checks", ntests, xfers, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== etx_core.f ====
src/etx_pkg.sv
src/etx_fifo.sv
src/etx_arbiter.sv
src/etx_cfg.sv
src/etx_remap.sv
src/etx_protocol.sv
src/etx_core.sv
testbench/etx_core_assert.sv
testbench/etx_core_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f etx_core.f \
		--top-module etx_core_tb -Mdir obj_dir -o Vetx_core_tb

run: compile
	./obj_dir/Vetx_core_tb | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
